// ==== Bender.yml ====
package:
  name: bpu

sources:
  - include_dirs:
      - .
    files:
      - bpu_pkg.sv
      - bpu_update_if.sv
      - bpu_table.sv
      - bpu_predict.sv
      - bpu_trainer.sv
      - bpu_perf_counters.sv
      - bpu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - bpu_tb_assert.sv
      - bpu_tb.sv

// ==== bpu_consts.svh ====
`ifndef BPU_CONSTS_SVH
`define BPU_CONSTS_SVH

// pc and instruction width
`define XLEN 32

// global history length in bits
`define HIST_LEN 16

// table depths
`define BIMODAL_ENTRIES 512
`define TAGGED_ENTRIES 256

// stored tag width of the tagged tables
`define TAG_WIDTH 10

// only the upper tag bits take part in a match
`define PARTIAL_TAG_BITS 6

`endif

// ==== bpu_perf_counters.sv ====
`timescale 1ns/10ps

module bpu_perf_counters
    import bpu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    bpu_update_if.perf  upd,
    output logic [31:0] perf_total_o,
    output logic [31:0] perf_correct_o,
    output logic [31:0] perf_tagged_correct_o
);

    localparam logic [31:0] CNT_MAX = '1;

    logic tagged_hit;

    assign tagged_hit = upd.correct && (upd.provider != PROV_BIMODAL);

    // counters stick at the max value
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            perf_total_o          <= '0;
            perf_correct_o        <= '0;
            perf_tagged_correct_o <= '0;
        end else if (upd.valid) begin
            if (perf_total_o != CNT_MAX) begin
                perf_total_o <= perf_total_o + 32'd1;
            end
            if (upd.correct && perf_correct_o != CNT_MAX) begin
                perf_correct_o <= perf_correct_o + 32'd1;
            end
            if (tagged_hit && perf_tagged_correct_o != CNT_MAX) begin
                perf_tagged_correct_o <= perf_tagged_correct_o + 32'd1;
            end
        end
    end

endmodule

// ==== bpu_pkg.sv ====
`include "bpu_consts.svh"

package bpu_pkg;

    typedef logic [`XLEN-1:0] xlen_t;
    typedef logic [`HIST_LEN-1:0] hist_t;
    typedef logic [$clog2(`BIMODAL_ENTRIES)-1:0] bm_idx_t;
    typedef logic [$clog2(`TAGGED_ENTRIES)-1:0] tbl_idx_t;
    typedef logic [`TAG_WIDTH-1:0] tag_t;

    // 2-bit saturating counter, msb gives the direction
    typedef logic [1:0] ctr_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
        ctr_t ctr;
    } tagged_entry_t;

    typedef enum logic [1:0] {
        PROV_BIMODAL = 2'd0,
        PROV_T0      = 2'd1,
        PROV_T1      = 2'd2
    } provider_e;

    // weakly not taken
    localparam ctr_t CTR_WEAK_NT = 2'b01;

    localparam tagged_entry_t TAGGED_RESET = '{valid: 1'b0, tag: '0, ctr: CTR_WEAK_NT};

    function automatic bm_idx_t bimodal_index(input xlen_t pc);
        return pc[9:1];
    endfunction

    // short history folds the low history byte into the index
    function automatic tbl_idx_t t0_index(input xlen_t pc, input hist_t hist);
        return pc[7:0] ^ hist[7:0];
    endfunction

    function automatic tbl_idx_t t1_index(input xlen_t pc, input hist_t hist);
        return pc[7:0] ^ hist[15:8];
    endfunction

    function automatic tag_t t0_tag(input xlen_t pc, input hist_t hist);
        return pc[17:8] ^ hist[15:6];
    endfunction

    function automatic tag_t t1_tag(input xlen_t pc, input hist_t hist);
        return pc[17:8] ^ {{(`TAG_WIDTH - 8){1'b0}}, hist[7:0]};
    endfunction

    // valid entry whose upper tag bits agree
    function automatic logic partial_match(input tagged_entry_t entry, input tag_t tag);
        return entry.valid &&
            (entry.tag[`TAG_WIDTH-1 -: `PARTIAL_TAG_BITS] ==
             tag[`TAG_WIDTH-1 -: `PARTIAL_TAG_BITS]);
    endfunction

endpackage

// ==== bpu_predict.sv ====
`timescale 1ns/10ps

module bpu_predict
    import bpu_pkg::*;
(
    input  xlen_t         if_pc_i,
    input  xlen_t         if_inst_i,
    input  hist_t         history_i,

    output bm_idx_t       bm_idx_o,
    input  ctr_t          bm_data_i,
    output tbl_idx_t      t0_idx_o,
    input  tagged_entry_t t0_data_i,
    output tbl_idx_t      t1_idx_o,
    input  tagged_entry_t t1_data_i,

    output logic          pred_branch_o,
    output logic          pred_taken_o,
    output xlen_t         pred_pc_o,
    output provider_e     pred_provider_o
);

    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    logic      is_branch;
    logic      is_jal;
    logic      t0_hit;
    logic      t1_hit;
    xlen_t     b_imm;
    xlen_t     j_imm;
    provider_e cond_provider;
    logic      cond_taken;

    assign bm_idx_o = bimodal_index(if_pc_i);
    assign t0_idx_o = t0_index(if_pc_i, history_i);
    assign t1_idx_o = t1_index(if_pc_i, history_i);

    assign t0_hit = partial_match(t0_data_i, t0_tag(if_pc_i, history_i));
    assign t1_hit = partial_match(t1_data_i, t1_tag(if_pc_i, history_i));

    assign is_branch = (if_inst_i[6:0] == OPC_BRANCH);
    assign is_jal    = (if_inst_i[6:0] == OPC_JAL);

    // sign-extended B and J immediates
    assign b_imm = {{20{if_inst_i[31]}}, if_inst_i[7], if_inst_i[30:25],
                    if_inst_i[11:8], 1'b0};
    assign j_imm = {{12{if_inst_i[31]}}, if_inst_i[19:12], if_inst_i[20],
                    if_inst_i[30:21], 1'b0};

    // longest history wins
    always_comb begin
        if (t1_hit) begin
            cond_provider = PROV_T1;
            cond_taken    = t1_data_i.ctr[1];
        end else if (t0_hit) begin
            cond_provider = PROV_T0;
            cond_taken    = t0_data_i.ctr[1];
        end else begin
            cond_provider = PROV_BIMODAL;
            cond_taken    = bm_data_i[1];
        end
    end

    always_comb begin
        pred_branch_o   = 1'b0;
        pred_taken_o    = 1'b0;
        pred_pc_o       = if_pc_i + 32'd4;
        pred_provider_o = PROV_BIMODAL;
        if (is_jal) begin
            // jal is always taken, no table involved
            pred_branch_o = 1'b1;
            pred_taken_o  = 1'b1;
            pred_pc_o     = if_pc_i + j_imm;
        end else if (is_branch) begin
            pred_branch_o   = 1'b1;
            pred_taken_o    = cond_taken;
            pred_provider_o = cond_provider;
            if (cond_taken) begin
                pred_pc_o = if_pc_i + b_imm;
            end
        end
    end

endmodule

// ==== bpu_table.sv ====
`timescale 1ns/10ps

module bpu_table #(
    parameter int DEPTH = 256,
    parameter type entry_t = logic [1:0],
    parameter entry_t RESET_VAL = '0
) (
    input  logic                     clk,
    input  logic                     rst,

    // port 0, fetch side
    input  logic [$clog2(DEPTH)-1:0] rd0_idx_i,
    output entry_t                   rd0_data_o,

    // port 1, update side
    input  logic [$clog2(DEPTH)-1:0] rd1_idx_i,
    output entry_t                   rd1_data_o,

    input  logic                     wr_en_i,
    input  logic [$clog2(DEPTH)-1:0] wr_idx_i,
    input  entry_t                   wr_data_i
);

    entry_t mem [DEPTH];

    // whole table returns to its cold state on reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= RESET_VAL;
            end
        end else if (wr_en_i) begin
            mem[wr_idx_i] <= wr_data_i;
        end
    end

    // asynchronous reads, a same-cycle write shows up next cycle
    assign rd0_data_o = mem[rd0_idx_i];
    assign rd1_data_o = mem[rd1_idx_i];

endmodule

// ==== bpu_tb.sv ====
`timescale 1ns/10ps

`include "bpu_consts.svh"

module bpu_tb
    import bpu_pkg::*;
;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 4;
    localparam xlen_t BR_PC     = 32'h0000_1000;
    localparam xlen_t BR_TARGET = 32'h0000_1080;
    // shares no table entry with BR_PC while training
    localparam xlen_t OTHER_PC  = 32'h0000_2008;

    typedef struct {
        string       name;
        logic        rst_first;
        xlen_t       pc;
        xlen_t       inst;
        logic        upd_valid;
        logic        upd_taken;
        logic        upd_correct;
        xlen_t       upd_pc;
        hist_t       upd_hist;
        provider_e   upd_prov;
        logic        exp_branch;
        logic        exp_taken;
        xlen_t       exp_pc;
        provider_e   exp_prov;
        hist_t       exp_hist;
        logic [31:0] exp_total;
        logic [31:0] exp_correct;
        logic [31:0] exp_tagged;
    } row_t;

    logic        clk;
    logic        rst;
    xlen_t       if_pc_i;
    xlen_t       if_inst_i;
    logic        pred_branch_o;
    logic        pred_taken_o;
    xlen_t       pred_pc_o;
    provider_e   pred_provider_o;
    hist_t       pred_history_o;
    logic        upd_valid_i;
    logic        upd_taken_i;
    logic        upd_correct_i;
    xlen_t       upd_pc_i;
    hist_t       upd_history_i;
    provider_e   upd_provider_i;
    logic [31:0] perf_total_o;
    logic [31:0] perf_correct_o;
    logic [31:0] perf_tagged_correct_o;

    row_t        rows[$];
    logic        table_ready = 1'b0;
    integer      seed;
    int          checks = 0;
    int          errors = 0;

    // expected state while the table is built
    hist_t       model_hist;
    logic [31:0] model_total;
    logic [31:0] model_correct;
    logic [31:0] model_tagged;

    bpu_top i_bpu_top (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic xlen_t encode_jal(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
    endfunction

    // beq x1, x2
    function automatic xlen_t encode_beq(input logic [12:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic random_nonbranch(output xlen_t inst);
        inst = $random(seed);
        // flipping bit 2 moves either control opcode to a plain one
        if (inst[6:0] == 7'b1100011 || inst[6:0] == 7'b1101111) begin
            inst[2] = ~inst[2];
        end
    endtask

    task automatic push_row(input string name, input logic rst_first, input xlen_t pc,
                            input xlen_t inst, input logic e_branch, input logic e_taken,
                            input xlen_t e_pc, input provider_e e_prov);
        row_t r;
        if (rst_first) begin
            model_hist    = '0;
            model_total   = '0;
            model_correct = '0;
            model_tagged  = '0;
        end
        r.name        = name;
        r.rst_first   = rst_first;
        r.pc          = pc;
        r.inst        = inst;
        r.upd_valid   = 1'b0;
        r.upd_taken   = 1'b0;
        r.upd_correct = 1'b0;
        r.upd_pc      = '0;
        r.upd_hist    = '0;
        r.upd_prov    = PROV_BIMODAL;
        r.exp_branch  = e_branch;
        r.exp_taken   = e_taken;
        r.exp_pc      = e_pc;
        r.exp_prov    = e_prov;
        r.exp_hist    = model_hist;
        r.exp_total   = model_total;
        r.exp_correct = model_correct;
        r.exp_tagged  = model_tagged;
        rows.push_back(r);
    endtask

    // update carries the history seen at prediction time
    task automatic attach_update(input logic taken, input logic correct, input xlen_t pc,
                                 input provider_e prov);
        row_t r;
        r = rows[rows.size() - 1];
        r.upd_valid   = 1'b1;
        r.upd_taken   = taken;
        r.upd_correct = correct;
        r.upd_pc      = pc;
        r.upd_hist    = model_hist;
        r.upd_prov    = prov;
        rows[rows.size() - 1] = r;
        model_hist  = {model_hist[`HIST_LEN-2:0], taken};
        model_total = model_total + 1;
        if (correct) begin
            model_correct = model_correct + 1;
        end
        if (correct && prov != PROV_BIMODAL) begin
            model_tagged = model_tagged + 1;
        end
    endtask

    // random non-branch fetches, optionally with updates at OTHER_PC
    task automatic steer(input int n, input logic with_update, input logic taken,
                         input logic correct);
        xlen_t pc;
        xlen_t inst;
        for (int i = 0; i < n; i++) begin
            pc = $random(seed) & 32'hFFFF_FFFC;
            random_nonbranch(inst);
            push_row($sformatf("random_%0d", rows.size()), 1'b0, pc, inst, 1'b0, 1'b0,
                     pc + 32'd4, PROV_BIMODAL);
            if (with_update) begin
                attach_update(taken, correct, OTHER_PC, PROV_BIMODAL);
            end
        end
    endtask

    task automatic build_table();
        xlen_t beq;
        beq = encode_beq(13'h080);
        push_row("nop", 1'b0, 32'h100, 32'h0000_0013, 1'b0, 1'b0, 32'h104, PROV_BIMODAL);
        steer(3, 1'b0, 1'b0, 1'b0);
        push_row("jal_cold", 1'b0, 32'h200, encode_jal(21'h40), 1'b1, 1'b1, 32'h240,
                 PROV_BIMODAL);
        push_row("br_cold", 1'b0, BR_PC, beq, 1'b1, 1'b0, BR_PC + 32'd4, PROV_BIMODAL);
        // mispredicted by the base table, T1 gets an entry for history 0
        attach_update(1'b1, 1'b0, BR_PC, PROV_BIMODAL);
        push_row("br_t1_partial", 1'b0, BR_PC, beq, 1'b1, 1'b1, BR_TARGET, PROV_T1);
        attach_update(1'b1, 1'b1, BR_PC, PROV_T1);
        steer(3, 1'b1, 1'b0, 1'b1);
        // history 0x18 breaks the partial tag, bimodal is now 11
        push_row("br_bimodal_taken", 1'b0, BR_PC, beq, 1'b1, 1'b1, BR_TARGET, PROV_BIMODAL);
        steer(13, 1'b1, 1'b0, 1'b1);
        push_row("jal_trained", 1'b0, 32'h300, encode_jal(21'h1F_FFE0), 1'b1, 1'b1,
                 32'h2E0, PROV_BIMODAL);
        push_row("br_t1_alloc", 1'b0, BR_PC, beq, 1'b1, 1'b1, BR_TARGET, PROV_T1);
        push_row("reset_cold_br", 1'b1, BR_PC, beq, 1'b1, 1'b0, BR_PC + 32'd4, PROV_BIMODAL);
        push_row("reset_jal", 1'b0, 32'h200, encode_jal(21'h40), 1'b1, 1'b1, 32'h240,
                 PROV_BIMODAL);
        steer(4, 1'b1, 1'b1, 1'b0);
        steer(2, 1'b1, 1'b0, 1'b1);
        push_row("final_counts", 1'b0, 32'h100, 32'h0000_0013, 1'b0, 1'b0, 32'h104,
                 PROV_BIMODAL);
    endtask

    task automatic check_value(input string name, input string field, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("FAIL %s %s: expected 0x%0h, actual 0x%0h", name, field, exp, act);
        end
    endtask

    task automatic apply_row(input row_t r);
        @(negedge clk);
        if (r.rst_first) begin
            rst         = 1'b1;
            upd_valid_i = 1'b0;
            @(negedge clk);
            rst = 1'b0;
        end
        if_pc_i        = r.pc;
        if_inst_i      = r.inst;
        upd_valid_i    = r.upd_valid;
        upd_taken_i    = r.upd_taken;
        upd_correct_i  = r.upd_correct;
        upd_pc_i       = r.upd_pc;
        upd_history_i  = r.upd_hist;
        upd_provider_i = r.upd_prov;
        // sample halfway through the low phase
        #(CLK_PERIOD / 4);
        check_value(r.name, "branch", r.exp_branch, pred_branch_o);
        check_value(r.name, "taken", r.exp_taken, pred_taken_o);
        check_value(r.name, "next_pc", r.exp_pc, pred_pc_o);
        check_value(r.name, "provider", r.exp_prov, pred_provider_o);
        check_value(r.name, "history", r.exp_hist, pred_history_o);
        check_value(r.name, "total", r.exp_total, perf_total_o);
        check_value(r.name, "correct", r.exp_correct, perf_correct_o);
        check_value(r.name, "tagged_correct", r.exp_tagged, perf_tagged_correct_o);
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        if_pc_i        = '0;
        if_inst_i      = '0;
        upd_valid_i    = 1'b0;
        upd_taken_i    = 1'b0;
        upd_correct_i  = 1'b0;
        upd_pc_i       = '0;
        upd_history_i  = '0;
        upd_provider_i = PROV_BIMODAL;
        seed           = 32'h3246_7154;
        model_hist     = '0;
        model_total    = '0;
        model_correct  = '0;
        model_tagged   = '0;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        @(negedge clk);
        upd_valid_i = 1'b0;
        $display("checks: %0d, value errors: %0d, assertion failures: %0d", checks, errors,
                 i_bpu_top.i_assert.assert_failures);
        if (errors == 0 && i_bpu_top.i_assert.assert_failures == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // four times the nominal run length
    initial begin
        wait (table_ready);
        #((rows.size() + RESET_CYCLES) * CLK_PERIOD * 4);
        $display("watchdog expired before all table rows were applied");
        $display("Test failed");
        $finish;
    end

endmodule

// ==== bpu_tb_assert.sv ====
`timescale 1ns/10ps

`include "bpu_consts.svh"

module bpu_tb_assert
    import bpu_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input xlen_t if_pc_i,
    input logic  pred_branch_o,
    input logic  pred_taken_o,
    input xlen_t pred_pc_o,
    input hist_t pred_history_o,
    input logic  upd_valid_i,
    input logic  upd_taken_i
);

    int assert_failures = 0;

    // only a decoded branch or jump can be predicted taken
    a_taken_is_branch: assert property (
        @(posedge clk) disable iff (rst) pred_taken_o |-> pred_branch_o
    ) else begin
        assert_failures++;
        $error("taken prediction without a decoded branch");
    end

    a_fall_through: assert property (
        @(posedge clk) disable iff (rst) !pred_taken_o |-> (pred_pc_o == if_pc_i + 32'd4)
    ) else begin
        assert_failures++;
        $error("not-taken prediction does not point to the next sequential pc");
    end

    // newest outcome enters at bit 0
    a_history_shift: assert property (
        @(posedge clk) disable iff (rst)
        upd_valid_i |=> (pred_history_o ==
            {$past(pred_history_o[`HIST_LEN-2:0]), $past(upd_taken_i)})
    ) else begin
        assert_failures++;
        $error("global history did not shift by one step after an update");
    end

endmodule

bind bpu_top bpu_tb_assert i_assert (
    .clk(clk),
    .rst(rst),
    .if_pc_i(if_pc_i),
    .pred_branch_o(pred_branch_o),
    .pred_taken_o(pred_taken_o),
    .pred_pc_o(pred_pc_o),
    .pred_history_o(pred_history_o),
    .upd_valid_i(upd_valid_i),
    .upd_taken_i(upd_taken_i)
);

// ==== bpu_top.sv ====
`timescale 1ns/10ps

`include "bpu_consts.svh"

module bpu_top
    import bpu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // fetch
    input  xlen_t       if_pc_i,
    input  xlen_t       if_inst_i,
    output logic        pred_branch_o,
    output logic        pred_taken_o,
    output xlen_t       pred_pc_o,
    output provider_e   pred_provider_o,
    output hist_t       pred_history_o,

    // resolved branch from execute
    input  logic        upd_valid_i,
    input  logic        upd_taken_i,
    input  logic        upd_correct_i,
    input  xlen_t       upd_pc_i,
    input  hist_t       upd_history_i,
    input  provider_e   upd_provider_i,

    output logic [31:0] perf_total_o,
    output logic [31:0] perf_correct_o,
    output logic [31:0] perf_tagged_correct_o
);

    bm_idx_t       bm_pred_idx, bm_upd_idx;
    ctr_t          bm_pred_data, bm_upd_data, bm_wr_data;
    logic          bm_wr_en;
    tbl_idx_t      t0_pred_idx, t0_upd_idx, t1_pred_idx, t1_upd_idx;
    tagged_entry_t t0_pred_data, t0_upd_data, t0_wr_data;
    tagged_entry_t t1_pred_data, t1_upd_data, t1_wr_data;
    logic          t0_wr_en, t1_wr_en;

    bpu_update_if upd_if ();

    assign upd_if.valid    = upd_valid_i;
    assign upd_if.taken    = upd_taken_i;
    assign upd_if.correct  = upd_correct_i;
    assign upd_if.pc       = upd_pc_i;
    assign upd_if.history  = upd_history_i;
    assign upd_if.provider = upd_provider_i;

    // trainer writes at the same index it reads on port 1
    bpu_table #(.DEPTH(`BIMODAL_ENTRIES), .entry_t(ctr_t), .RESET_VAL(CTR_WEAK_NT)) i_bm_table (
        .clk, .rst,
        .rd0_idx_i(bm_pred_idx), .rd0_data_o(bm_pred_data),
        .rd1_idx_i(bm_upd_idx),  .rd1_data_o(bm_upd_data),
        .wr_en_i(bm_wr_en), .wr_idx_i(bm_upd_idx), .wr_data_i(bm_wr_data)
    );

    bpu_table #(.DEPTH(`TAGGED_ENTRIES), .entry_t(tagged_entry_t),
                .RESET_VAL(TAGGED_RESET)) i_t0_table (
        .clk, .rst,
        .rd0_idx_i(t0_pred_idx), .rd0_data_o(t0_pred_data),
        .rd1_idx_i(t0_upd_idx),  .rd1_data_o(t0_upd_data),
        .wr_en_i(t0_wr_en), .wr_idx_i(t0_upd_idx), .wr_data_i(t0_wr_data)
    );

    bpu_table #(.DEPTH(`TAGGED_ENTRIES), .entry_t(tagged_entry_t),
                .RESET_VAL(TAGGED_RESET)) i_t1_table (
        .clk, .rst,
        .rd0_idx_i(t1_pred_idx), .rd0_data_o(t1_pred_data),
        .rd1_idx_i(t1_upd_idx),  .rd1_data_o(t1_upd_data),
        .wr_en_i(t1_wr_en), .wr_idx_i(t1_upd_idx), .wr_data_i(t1_wr_data)
    );

    bpu_predict i_predict (
        .if_pc_i, .if_inst_i, .history_i(pred_history_o),
        .bm_idx_o(bm_pred_idx), .bm_data_i(bm_pred_data),
        .t0_idx_o(t0_pred_idx), .t0_data_i(t0_pred_data),
        .t1_idx_o(t1_pred_idx), .t1_data_i(t1_pred_data),
        .pred_branch_o, .pred_taken_o, .pred_pc_o, .pred_provider_o
    );

    bpu_trainer i_trainer (
        .clk, .rst, .upd(upd_if.trainer), .history_o(pred_history_o),
        .bm_idx_o(bm_upd_idx), .bm_data_i(bm_upd_data),
        .bm_wr_en_o(bm_wr_en), .bm_wr_data_o(bm_wr_data),
        .t0_idx_o(t0_upd_idx), .t0_data_i(t0_upd_data),
        .t0_wr_en_o(t0_wr_en), .t0_wr_data_o(t0_wr_data),
        .t1_idx_o(t1_upd_idx), .t1_data_i(t1_upd_data),
        .t1_wr_en_o(t1_wr_en), .t1_wr_data_o(t1_wr_data)
    );

    bpu_perf_counters i_perf (
        .clk, .rst, .upd(upd_if.perf),
        .perf_total_o, .perf_correct_o, .perf_tagged_correct_o
    );

endmodule

// ==== bpu_trainer.sv ====
`timescale 1ns/10ps

`include "bpu_consts.svh"

module bpu_trainer
    import bpu_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    bpu_update_if.trainer upd,

    output hist_t         history_o,

    output bm_idx_t       bm_idx_o,
    input  ctr_t          bm_data_i,
    output logic          bm_wr_en_o,
    output ctr_t          bm_wr_data_o,

    output tbl_idx_t      t0_idx_o,
    input  tagged_entry_t t0_data_i,
    output logic          t0_wr_en_o,
    output tagged_entry_t t0_wr_data_o,

    output tbl_idx_t      t1_idx_o,
    input  tagged_entry_t t1_data_i,
    output logic          t1_wr_en_o,
    output tagged_entry_t t1_wr_data_o
);

    tag_t upd_t0_tag;
    tag_t upd_t1_tag;
    ctr_t strong_ctr;
    ctr_t weak_ctr;

    // saturating step toward the outcome
    function automatic ctr_t ctr_step(input ctr_t c, input logic taken);
        if (taken) begin
            return (c == 2'b11) ? c : c + 2'd1;
        end
        return (c == 2'b00) ? c : c - 2'd1;
    endfunction

    // global history with the newest outcome at bit 0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            history_o <= '0;
        end else if (upd.valid) begin
            history_o <= {history_o[`HIST_LEN-2:0], upd.taken};
        end
    end

    // lookup uses the snapshot rather than the live history
    assign bm_idx_o   = bimodal_index(upd.pc);
    assign t0_idx_o   = t0_index(upd.pc, upd.history);
    assign t1_idx_o   = t1_index(upd.pc, upd.history);
    assign upd_t0_tag = t0_tag(upd.pc, upd.history);
    assign upd_t1_tag = t1_tag(upd.pc, upd.history);

    assign strong_ctr = upd.taken ? 2'b11 : 2'b00;
    assign weak_ctr   = upd.taken ? 2'b10 : 2'b01;

    // base table trains on every resolved branch
    assign bm_wr_en_o   = upd.valid;
    assign bm_wr_data_o = ctr_step(bm_data_i, upd.taken);

    always_comb begin
        t0_wr_en_o   = 1'b0;
        t0_wr_data_o = t0_data_i;
        t1_wr_en_o   = 1'b0;
        t1_wr_data_o = t1_data_i;
        if (upd.valid) begin
            if (upd.correct) begin
                if (upd.provider == PROV_T1) begin
                    t1_wr_en_o       = 1'b1;
                    t1_wr_data_o.ctr = ctr_step(t1_data_i.ctr, upd.taken);
                end else if (upd.provider == PROV_T0) begin
                    t0_wr_en_o       = 1'b1;
                    t0_wr_data_o.ctr = ctr_step(t0_data_i.ctr, upd.taken);
                end
            end else if (upd.provider == PROV_T1) begin
                t1_wr_en_o       = 1'b1;
                t1_wr_data_o.ctr = strong_ctr;
            end else if (upd.provider == PROV_T0) begin
                t0_wr_en_o       = 1'b1;
                t0_wr_data_o.ctr = strong_ctr;
            end else if (!t1_data_i.valid || t1_data_i.tag != upd_t1_tag) begin
                // bimodal missed so the long table is tried first
                t1_wr_en_o   = 1'b1;
                t1_wr_data_o = '{valid: 1'b1, tag: upd_t1_tag, ctr: weak_ctr};
            end else if (!t0_data_i.valid || t0_data_i.tag != upd_t0_tag) begin
                t0_wr_en_o   = 1'b1;
                t0_wr_data_o = '{valid: 1'b1, tag: upd_t0_tag, ctr: weak_ctr};
            end
        end
    end

endmodule

// ==== bpu_update_if.sv ====
`timescale 1ns/10ps

interface bpu_update_if
    import bpu_pkg::*;
;

    logic      valid;
    // actual outcome of the branch
    logic      taken;
    // prediction agreed with the outcome
    logic      correct;
    xlen_t     pc;
    // history snapshot taken at prediction time
    hist_t     history;
    provider_e provider;

    modport src (
        output valid, taken, correct, pc, history, provider
    );

    modport trainer (
        input valid, taken, correct, pc, history, provider
    );

    // counters only need the outcome summary
    modport perf (
        input valid, correct, provider
    );

endinterface

// ==== project.f ====
+incdir+.
bpu_pkg.sv
bpu_update_if.sv
bpu_table.sv
bpu_predict.sv
bpu_trainer.sv
bpu_perf_counters.sv
bpu_top.sv
bpu_tb_assert.sv
bpu_tb.sv
